//--- bbcMemory.f
+incdir+include
verilog/bbcPkg.sv
verilog/timingIf.sv
verilog/cpuBusIf.sv
verilog/timingGenerator.sv
verilog/sheilaDecoder.sv
verilog/screenAddressMapper.sv
verilog/sharedRam.sv
verilog/sidewaysMemory.sv
verilog/bbcMemorySystem.sv
tb/tbBbcMemory.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbBbcMemory
FILELIST ?= bbcMemory.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	$(BIN)

clean:
	rm -rf $(OBJDIR)

//--- include/bbcMemoryRef.svh
`ifndef BBC_MEMORY_REF_SVH
`define BBC_MEMORY_REF_SVH

// Mirror of RAM and of every paged page
byte_t refRam [0:32767];
byte_t refPages [int];        // Keyed by page times 16 KiB plus offset
logic [3:0] refBank = 4'h0;   // Matches the bank register after reset

function automatic sheilaSelect_t refDecode(cpuAddr_t address, logic rnw);
	sheilaSelect_t sel;
	byte_t low;
	low = address[7:0];
	sel.crtc = low < 8'h08;
	sel.acia = low inside {[8'h08:8'h0F]};
	sel.videoUla = (low inside {[8'h20:8'h2F]}) && !rnw;
	sel.romSelect = (low inside {[8'h30:8'h3F]}) && !rnw;
	sel.sysVia = low inside {[8'h40:8'h5F]};
	sel.userVia = low inside {[8'h60:8'h7F]};
	sel.fdc = low inside {[8'h80:8'h9F]};
	sel.adlc = low inside {[8'hA0:8'hBF]};
	sel.adc = low inside {[8'hC0:8'hDF]};
	sel.tube = low >= 8'hE0;
	if (address[15:8] != sheilaPage)
		sel = '0;
	return sel;
endfunction

function automatic logic refSlow(sheilaSelect_t sel);
	return sel.sysVia | sel.userVia | sel.adc | sel.acia;
endfunction

function automatic ramAddr_t refVideoAddress(logic [13:0] framestore, logic [2:0] row,
	byte_t latch);
	logic [3:0] high;
	high = framestore[11:8];
	if (framestore[12]) begin
		case ({latch[screenLatchC1], latch[screenLatchC0]})
			2'b00: high = high + 4'd8;
			2'b01: high = high + 4'd12;
			2'b10: high = high + 4'd6;
			default: high = high + 4'd11;
		endcase
	end
	return {high, framestore[7:0], row};
endfunction

function automatic int refPageKey(cpuAddr_t address, int bankCount);
	int page;
	page = address[14] ? bankCount : int'(refBank) % bankCount;
	return page * 16384 + int'(address[13:0]);
endfunction

// Every write the testbench issues goes through here
function automatic void refWrite(cpuAddr_t address, byte_t data, logic romLoad,
	int bankCount);
	sheilaSelect_t sel;
	sel = refDecode(address, 1'b0);
	if (!address[15])
		refRam[address[14:0]] = data;
	else if (sel.romSelect)
		refBank = data[3:0];
	else if (romLoad && address[15:8] != sheilaPage)
		refPages[refPageKey(address, bankCount)] = data;
endfunction

function automatic byte_t refRead(cpuAddr_t address, int bankCount);
	int key;
	key = refPageKey(address, bankCount);
	if (!address[15])
		return refRam[address[14:0]];
	return refPages.exists(key) ? refPages[key] : 8'hxx;
endfunction

`endif

//--- tb/tbBbcMemory.sv
`timescale 1ns/100ps

module tbBbcMemory import bbcPkg::*; ();

	`include "bbcMemoryRef.svh"

	localparam logic [31:0] seed = 32'h7e2affe0;
	localparam int ramTests = 64;
	localparam int pageTests = 16;
	localparam int bankRounds = 8;
	localparam int decodeTests = 200;
	localparam int videoTests = 50;   // Per screen size
	// Upper bound on bus operations with the bank loop sized for 16 banks
	localparam int opCount = 2 * ramTests + 16 * (pageTests + 1) + bankRounds * (pageTests + 1) +
		6 * pageTests + decodeTests + 32768 + 4 * (videoTests + 2) + 1;

	logic PIXELCLK = 1'b0;
	logic reset = 1'b1;
	cpuAddr_t cpuAddress;
	byte_t cpuWriteData;
	logic cpuRnW;
	logic romLoad;
	logic [2:0] latchAddress;
	logic latchData;
	logic latchWrite;
	logic [13:0] framestoreAddress;
	logic [2:0] rowAddress;
	byte_t cpuReadData;
	logic cpuStep;
	logic phi2;
	sheilaSelect_t selects;
	logic slowAccess;
	byte_t latchBits;
	logic [3:0] romBank;
	byte_t videoData;

	// Expected values for the cycle in flight
	sheilaSelect_t expSelect = '0;
	logic expReadValid = 1'b0;
	byte_t expRead;
	logic expVideoValid = 1'b0;
	byte_t expVideo;
	byte_t latchModel = '0;
	int bankCount;
	cpuAddr_t ramAddrs[$];
	cpuAddr_t osAddrs[$];
	cpuAddr_t swAddrs[$];

	bbcMemorySystem u_bbcMemorySystem (.*);

	always #2 PIXELCLK = ~PIXELCLK;

	task automatic reportFailure(string message);
		$display("%s", message);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkByte(string what, byte_t actual, byte_t expected);
		if (actual !== expected)
			reportFailure($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic checkSelect(string what, sheilaSelect_t actual, sheilaSelect_t expected);
		if (actual !== expected)
			reportFailure($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	task automatic checkCount(string what, int actual, int expected);
		if (actual != expected)
			reportFailure($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	// One CPU cycle, driven on the falling edge after the previous step
	task automatic busOp(cpuAddr_t address, byte_t data, logic rnw, logic checkRead);
		cpuAddress = address;
		cpuWriteData = data;
		cpuRnW = rnw;
		expSelect = refDecode(address, rnw);
		expReadValid = checkRead;
		expRead = refRead(address, bankCount);
		do @(negedge PIXELCLK); while (!cpuStep);
		@(negedge PIXELCLK);   // Step edge has passed
		if (!rnw)
			refWrite(address, data, romLoad, bankCount);
		if (latchWrite)
			latchModel[latchAddress] = latchData;
		latchWrite = 1'b0;
	endtask

	task automatic setLatch(int bitIndex, logic value);
		latchAddress = 3'(bitIndex);
		latchData = value;
		latchWrite = 1'b1;
		busOp(16'h0000, 8'h00, 1'b1, 1'b0);
	endtask

	initial begin : compareProcess
		int sinceStep;
		int phase;   // Free-running PIXELCLK phase
		logic firstStep;
		logic videoPending;
		byte_t pendingVideo;
		sinceStep = 0;
		phase = 0;
		firstStep = 1'b1;
		videoPending = 1'b0;
		@(negedge reset);
		forever begin
			@(negedge PIXELCLK);
			sinceStep++;
			phase = (phase + 1) % phaseCount;
			// Second half of every processor cycle
			checkCount("phi2", int'(phi2), int'(phase >= phaseCount / 2));
			if (cpuStep) begin
				// Phase 15 after reset, then 16 or 32 cycles apart
				checkCount("cpuStep spacing", sinceStep, (firstStep ? phaseCount - 1 : phaseCount)
					+ (refSlow(expSelect) ? phaseCount : 0));
				checkSelect("selects", selects, expSelect);
				checkCount("slowAccess", int'(slowAccess), int'(refSlow(expSelect)));
				checkByte("latchBits", latchBits, latchModel);
				checkByte("romBank", byte_t'(romBank), byte_t'(refBank));
				if (expReadValid)
					checkByte("cpuReadData", cpuReadData, expRead);
				if (videoPending)
					checkByte("videoData", videoData, pendingVideo);   // Read one step earlier
				videoPending = expVideoValid;
				pendingVideo = expVideo;
				sinceStep = 0;
				firstStep = 1'b0;
			end
		end
	end

	initial begin : stimulus
		cpuAddr_t address;
		int pick;
		void'($urandom(seed));
		bankCount = u_bbcMemorySystem.bankCount;
		cpuAddress = '0;
		cpuWriteData = '0;
		cpuRnW = 1'b1;
		romLoad = 1'b0;
		latchAddress = '0;
		latchData = 1'b0;
		latchWrite = 1'b0;
		framestoreAddress = '0;
		rowAddress = '0;
		repeat (3) @(posedge PIXELCLK);
		@(negedge PIXELCLK);
		reset = 1'b0;
		for (int i = 0; i < ramTests; i++) begin
			address = cpuAddr_t'($urandom) & 16'h7FFF;
			ramAddrs.push_back(address);
			busOp(address, byte_t'($urandom), 1'b0, 1'b0);
		end
		while (ramAddrs.size() > 0) begin   // Random read-back order
			pick = $urandom % ramAddrs.size();
			busOp(ramAddrs[pick], 8'h00, 1'b1, 1'b1);
			ramAddrs.delete(pick);
		end
		for (int i = 0; i < pageTests; i++) begin
			osAddrs.push_back(16'hC000 | cpuAddr_t'($urandom % 32'h3E00));   // Skips SHEILA
			swAddrs.push_back(16'h8000 | (cpuAddr_t'($urandom) & 16'h3FFF));
		end
		romLoad = 1'b1;
		foreach (osAddrs[i])
			busOp(osAddrs[i], byte_t'($urandom), 1'b0, 1'b0);
		for (int bank = 0; bank < bankCount; bank++) begin
			busOp(16'hFE30, byte_t'(bank), 1'b0, 1'b0);
			foreach (swAddrs[i])
				busOp(swAddrs[i], byte_t'($urandom), 1'b0, 1'b0);
		end
		romLoad = 1'b0;
		for (int round = 0; round < bankRounds; round++) begin
			busOp(16'hFE30, byte_t'($urandom), 1'b0, 1'b0);   // Any value since the page is modulo
			foreach (swAddrs[i])
				busOp(swAddrs[i], 8'h00, 1'b1, 1'b1);
		end
		foreach (osAddrs[i])
			busOp(osAddrs[i], 8'h00, 1'b1, 1'b1);
		// Pages are read only without romLoad
		foreach (swAddrs[i])
			busOp(swAddrs[i], byte_t'($urandom), 1'b0, 1'b0);
		foreach (osAddrs[i])
			busOp(osAddrs[i], byte_t'($urandom), 1'b0, 1'b0);
		foreach (swAddrs[i])
			busOp(swAddrs[i], 8'h00, 1'b1, 1'b1);
		foreach (osAddrs[i])
			busOp(osAddrs[i], 8'h00, 1'b1, 1'b1);
		for (int i = 0; i < decodeTests; i++) begin
			address = cpuAddr_t'($urandom);
			if (i % 2 == 0)
				address[15:8] = sheilaPage;
			busOp(address, byte_t'($urandom), 1'($urandom), 1'b0);
		end
		for (int a = 0; a < 32768; a++)
			busOp(cpuAddr_t'(a), byte_t'(a ^ (a >> 7)), 1'b0, 1'b0);
		for (int size = 0; size < 4; size++) begin
			setLatch(screenLatchC0, size[0]);
			setLatch(screenLatchC1, size[1]);
			for (int i = 0; i < videoTests; i++) begin
				framestoreAddress = 14'($urandom);
				rowAddress = 3'($urandom);
				expVideo = refRam[refVideoAddress(framestoreAddress, rowAddress, latchModel)];
				expVideoValid = 1'b1;
				busOp(16'h0000, 8'h00, 1'b1, 1'b0);
			end
			expVideoValid = 1'b0;
		end
		busOp(16'h0000, 8'h00, 1'b1, 1'b0);   // Lets the last video byte be compared
		$display("Everything OK");
		$finish;
	end

	initial begin : watchdog
		#(opCount * 32 * 4 * 2);
		reportFailure("The run timed out before all bus operations finished");
	end

endmodule

//--- verilog/bbcMemorySystem.sv
`timescale 1ns/100ps

module bbcMemorySystem import bbcPkg::*; #(
	parameter int bankCount = 4
) (
	input  logic PIXELCLK,
	input  logic reset,
	input  cpuAddr_t cpuAddress,
	input  byte_t cpuWriteData,
	input  logic cpuRnW,
	input  logic romLoad,
	input  logic [2:0] latchAddress,
	input  logic latchData,
	input  logic latchWrite,
	input  logic [13:0] framestoreAddress,
	input  logic [2:0] rowAddress,
	output byte_t cpuReadData,
	output logic cpuStep,
	output logic phi2,
	output sheilaSelect_t selects,
	output logic slowAccess,
	output byte_t latchBits,
	output logic [3:0] romBank,
	output byte_t videoData
);

	timingIf timing ();
	cpuBusIf bus ();

	logic romSelect;
	byte_t ramReadData;
	ramAddr_t videoAddress;

	assign bus.address = cpuAddress;
	assign bus.writeData = cpuWriteData;
	assign bus.rnw = cpuRnW;
	assign bus.romLoad = romLoad;

	assign cpuStep = timing.cpuStep;
	assign phi2 = timing.phi2;
	assign slowAccess = timing.slowAccess;

	timingGenerator u_timingGenerator (
		.PIXELCLK(PIXELCLK), .reset(reset), .timing(timing)
	);

	sheilaDecoder u_sheilaDecoder (
		.bus(bus), .timing(timing), .selects(selects), .romSelect(romSelect)
	);

	screenAddressMapper u_screenAddressMapper (
		.PIXELCLK(PIXELCLK), .reset(reset), .timing(timing),
		.latchAddress(latchAddress), .latchData(latchData), .latchWrite(latchWrite),
		.framestoreAddress(framestoreAddress), .rowAddress(rowAddress),
		.latchBits(latchBits), .videoAddress(videoAddress)
	);

	sharedRam u_sharedRam (
		.PIXELCLK(PIXELCLK), .timing(timing), .bus(bus), .videoAddress(videoAddress),
		.ramReadData(ramReadData), .videoData(videoData)
	);

	sidewaysMemory #(.bankCount(bankCount)) u_sidewaysMemory (
		.PIXELCLK(PIXELCLK), .reset(reset), .timing(timing), .bus(bus),
		.romSelect(romSelect), .ramReadData(ramReadData),
		.cpuReadData(cpuReadData), .romBank(romBank)
	);

endmodule

//--- verilog/sidewaysMemory.sv
`timescale 1ns/100ps

module sidewaysMemory import bbcPkg::*; #(
	parameter int bankCount = 4   // Power of two
) (
	input  logic PIXELCLK,
	input  logic reset,
	timingIf.user timing,
	cpuBusIf.consumer bus,
	input  logic romSelect,
	input  byte_t ramReadData,
	output byte_t cpuReadData,
	output logic [3:0] romBank
);

	localparam int pageSize = 2 ** $bits(pageAddr_t);
	localparam int pageBits = $clog2(bankCount + 1);
	localparam int osPage = bankCount;   // Last page is the OS

	// Sideways pages first, then the OS page
	byte_t pages [0:bankCount][0:pageSize-1];

	logic [pageBits-1:0] pageIndex;
	pageAddr_t pageOffset;
	byte_t pagedData;
	logic inSheila;
	logic pageWrite;

	assign pageOffset = bus.address[13:0];
	assign inSheila = bus.address[15:8] == sheilaPage;

	always_comb begin
		if (bus.address[14])
			pageIndex = pageBits'(osPage);                  // C000 to FFFF
		else
			pageIndex = pageBits'(romBank % bankCount);     // 8000 to BFFF
	end

	// Paged pages only take writes while the loader runs
	assign pageWrite = timing.cpuStep & bus.romLoad & ~bus.rnw &
		bus.address[15] & ~inSheila;

	// Bank latch at FE30
	always_ff @(posedge PIXELCLK) begin
		if (reset)
			romBank <= '0;
		else if (timing.cpuStep && romSelect)
			romBank <= bus.writeData[3:0];
	end

	always_ff @(posedge PIXELCLK) begin
		if (timing.ramEn && !timing.phi2)
			pagedData <= pages[pageIndex][pageOffset];
		if (pageWrite)
			pages[pageIndex][pageOffset] <= bus.writeData;
	end

	// Upper half of the map comes from the pages
	assign cpuReadData = bus.address[15] ? pagedData : ramReadData;

endmodule

//--- verilog/sharedRam.sv
`timescale 1ns/100ps

module sharedRam import bbcPkg::*; (
	input  logic PIXELCLK,
	timingIf.user timing,
	cpuBusIf.consumer bus,
	input  ramAddr_t videoAddress,
	output byte_t ramReadData,
	output byte_t videoData
);

	localparam int ramSize = 2 ** $bits(ramAddr_t);

	byte_t ram [0:ramSize-1];

	ramAddr_t cpuRamAddress;
	logic cpuSlot;
	logic videoSlot;
	logic ramWrite;

	assign cpuRamAddress = bus.address[14:0];
	assign cpuSlot = timing.ramEn & ~timing.phi2;   // Phase 7
	assign videoSlot = timing.ramEn & timing.phi2;  // Phase 15

	// CPU write lands at the end of its cycle, lower 32 KiB only
	assign ramWrite = timing.cpuStep & ~bus.rnw & ~bus.address[15];

	always_ff @(posedge PIXELCLK) begin
		if (cpuSlot)
			ramReadData <= ram[cpuRamAddress];
		if (videoSlot) begin
			videoData <= ram[videoAddress];   // Held for the whole next cycle
			if (ramWrite)
				ram[cpuRamAddress] <= bus.writeData;
		end
	end

endmodule

//--- verilog/screenAddressMapper.sv
`timescale 1ns/100ps

module screenAddressMapper import bbcPkg::*; (
	input  logic PIXELCLK,
	input  logic reset,
	timingIf.user timing,
	input  logic [2:0] latchAddress,
	input  logic latchData,
	input  logic latchWrite,
	input  logic [13:0] framestoreAddress,
	input  logic [2:0] rowAddress,
	output byte_t latchBits,
	output ramAddr_t videoAddress
);

	byte_t latch;
	logic [1:0] screenSize;
	logic [3:0] wrapOffset;
	logic [3:0] correctedHigh;

	// Addressable latch fed from system VIA port B
	always_ff @(posedge PIXELCLK) begin
		if (reset)
			latch <= '0;
		else if (timing.cpuStep && latchWrite)
			latch[latchAddress] <= latchData;
	end

	assign latchBits = latch;
	assign screenSize = {latch[screenLatchC1], latch[screenLatchC0]};

	// Amount that pulls an overflowing address back into the screen
	always_comb begin
		case (screenSize)
			2'b00: wrapOffset = 4'd8;    // 16 KiB screen
			2'b01: wrapOffset = 4'd12;   // 8 KiB screen
			2'b10: wrapOffset = 4'd6;    // 20 KiB screen
			default: wrapOffset = 4'd11; // 10 KiB
		endcase
	end

	// Bit 12 set means the CRTC ran past the top of RAM
	assign correctedHigh = framestoreAddress[12] ?
		framestoreAddress[11:8] + wrapOffset : framestoreAddress[11:8];

	// Character row picks the byte within each 8-byte cell
	assign videoAddress = {correctedHigh, framestoreAddress[7:0], rowAddress};

endmodule

//--- verilog/sheilaDecoder.sv
`timescale 1ns/100ps

module sheilaDecoder import bbcPkg::*; (
	cpuBusIf.consumer bus,
	timingIf.user timing,
	output sheilaSelect_t selects,
	output logic romSelect
);

	logic inSheila;
	logic cpuWrite;

	assign inSheila = bus.address[15:8] == sheilaPage;
	assign cpuWrite = ~bus.rnw;

	always_comb begin
		selects = '0;
		if (inSheila) begin
			case (bus.address[7:4])
				4'h0: begin
					// CRTC and ACIA share the first 16 bytes
					selects.crtc = ~bus.address[3];
					selects.acia = bus.address[3];
				end
				4'h2: selects.videoUla = cpuWrite;    // Write only
				4'h3: selects.romSelect = cpuWrite;   // Write only
				4'h4, 4'h5: selects.sysVia = 1'b1;
				4'h6, 4'h7: selects.userVia = 1'b1;
				4'h8, 4'h9: selects.fdc = 1'b1;
				4'hA, 4'hB: selects.adlc = 1'b1;
				4'hC, 4'hD: selects.adc = 1'b1;
				4'hE, 4'hF: selects.tube = 1'b1;
				default: ;   // FE10 to FE1F is a hole
			endcase
		end
	end

	assign romSelect = selects.romSelect;

	// These run off the 1 MHz bus
	assign timing.slowAccess = selects.sysVia | selects.userVia |
		selects.adc | selects.acia;

endmodule

//--- verilog/timingGenerator.sv
`timescale 1ns/100ps

module timingGenerator import bbcPkg::*; (
	input  logic PIXELCLK,
	input  logic reset,
	timingIf.generator timing
);

	localparam int phaseBits = $clog2(phaseCount);
	localparam int lastPhase = phaseCount - 1;
	localparam int cpuSlot = phaseCount / 2 - 1;   // Phase 7
	localparam int secondHalf = phaseCount / 2;    // phi2 starts here

	logic [phaseBits-1:0] phase;
	logic halfCycle;   // First half of a stretched cycle is done
	logic atLast;

	assign atLast = phase == phaseBits'(lastPhase);

	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			phase <= '0;
			halfCycle <= 1'b0;
		end else begin
			phase <= phase + 1'b1;   // Wraps at phaseCount
			// Slow cycles skip every other step
			if (atLast)
				halfCycle <= timing.slowAccess & ~halfCycle;
		end
	end

	// CPU slot at phase 7, video slot at the last phase
	assign timing.ramEn = atLast | (phase == phaseBits'(cpuSlot));
	assign timing.phi2 = phase >= phaseBits'(secondHalf);

	// 2 MHz normally, stretched to 1 MHz for slow peripherals
	assign timing.cpuStep = atLast & (~timing.slowAccess | halfCycle);

endmodule

//--- verilog/cpuBusIf.sv
`timescale 1ns/100ps

interface cpuBusIf import bbcPkg::*; ();

	cpuAddr_t address;
	byte_t    writeData;
	logic     rnw;      // High for a read
	logic     romLoad;  // Boot loader owns the paged pages

	// Everything inside the design only listens to the bus
	modport consumer (
		input address,
		input writeData,
		input rnw,
		input romLoad
	);

endinterface

//--- verilog/timingIf.sv
`timescale 1ns/100ps

interface timingIf ();

	logic ramEn;       // RAM slot strobe, phases 7 and 15
	logic phi2;        // Second half of the processor cycle
	logic cpuStep;     // CPU advances at this edge
	logic slowAccess;  // 1 MHz peripheral addressed

	modport generator (
		output ramEn,
		output phi2,
		output cpuStep,
		input  slowAccess
	);

	modport user (
		input  ramEn,
		input  phi2,
		input  cpuStep,
		output slowAccess
	);

endinterface

//--- verilog/bbcPkg.sv
package bbcPkg;

	typedef logic [7:0] byte_t;       // CPU and video data byte
	typedef logic [15:0] cpuAddr_t;   // Full 6502 address
	typedef logic [14:0] ramAddr_t;   // Shared 32 KiB RAM
	typedef logic [13:0] pageAddr_t;  // Offset inside a 16 KiB page

	// One bit per peripheral in the SHEILA page, active high
	typedef struct packed {
		logic crtc;       // FE00 to FE07
		logic acia;       // FE08 to FE0F
		logic videoUla;   // FE20 to FE2F, writes
		logic romSelect;  // FE30 to FE3F, writes
		logic sysVia;     // FE40 to FE5F
		logic userVia;    // FE60 to FE7F
		logic fdc;        // FE80 to FE9F
		logic adlc;       // FEA0 to FEBF
		logic adc;        // FEC0 to FEDF
		logic tube;       // FEE0 to FEFF
	} sheilaSelect_t;

	// High address byte of the I/O page
	localparam byte_t sheilaPage = 8'hFE;

	// PIXELCLK cycles per processor cycle
	localparam int phaseCount = 16;

	// Screen size bits in the addressable latch
	localparam int screenLatchC0 = 4;
	localparam int screenLatchC1 = 5;

endpackage
